//--- all.f
common/dump_pkg.sv
common/buf_rd_if.sv
hw/capture_control.sv
capture/capture_channel.sv
dump/dump_sequencer.sv
dump/uart_tx.sv
hw/hex_dump_top.sv
tb/tb_clock.sv
tb/tb_hex_dump.sv

//--- capture/capture_channel.sv
`timescale 1ns/10ps

module capture_channel #(
    parameter int WORD_BITS     = 16,
    parameter int CAPTURE_WORDS = 8,
    parameter int ADDR_BITS     = 3
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 sig,
    input  logic                 word_strobe,
    input  logic                 wr_en,
    input  logic [ADDR_BITS-1:0] wr_addr,
    buf_rd_if.buffer             rd
);

    logic [WORD_BITS-1:0] shift_q;   // deserializer, newest sample in bit 0
    logic [WORD_BITS-1:0] word_now;  // word ending with this cycle's sample
    logic [WORD_BITS-1:0] word_q;    // last completed word
    logic                 wr_pend;   // buffer write one cycle behind wr_en
    logic [ADDR_BITS-1:0] wr_addr_q;

    logic [WORD_BITS-1:0] mem [CAPTURE_WORDS];

    assign word_now = {shift_q[WORD_BITS-2:0], sig}; // MSB is the oldest sample

    always_ff @(posedge clk) begin
        shift_q <= word_now;
        if (word_strobe) begin
            word_q <= word_now; // latch on the word boundary
        end
        if (wr_en) begin
            wr_addr_q <= wr_addr;
        end
    end

    // write is retimed off the latch, keeps the shift path short
    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_pend <= 1'b0;
        end else begin
            wr_pend <= wr_en;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_pend) begin
            mem[wr_addr_q] <= word_q;
        end
    end

    // registered read port
    always_ff @(posedge clk) begin
        if (rd.rd_en) begin
            rd.rd_data <= mem[rd.rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            rd.rd_valid <= 1'b0;
        end else begin
            rd.rd_valid <= rd.rd_en;
        end
    end

    // reads only happen in the dump phase, writes only in the fill phase
    a_no_rd_during_wr: assert property (@(posedge clk) disable iff (!rst)
        !(rd.rd_en && wr_en))
        else $error("buffer read while capture writes");

endmodule

//--- common/buf_rd_if.sv
`timescale 1ns/10ps

interface buf_rd_if #(
    parameter int WORD_BITS = 16,
    parameter int ADDR_BITS = 3
);

    logic                 rd_en;    // one-cycle read request
    logic [ADDR_BITS-1:0] rd_addr;  // word address in the buffer
    logic [WORD_BITS-1:0] rd_data;  // registered read data
    logic                 rd_valid; // rd_data valid, one cycle after rd_en

    // dump side
    modport host (
        output rd_en,
        output rd_addr,
        input  rd_data,
        input  rd_valid
    );

    // capture buffer side
    modport buffer (
        input  rd_en,
        input  rd_addr,
        output rd_data,
        output rd_valid
    );

endinterface

//--- common/dump_pkg.sv
package dump_pkg;

    // capture phase, shared by the control FSM and the top level
    typedef enum logic [1:0] {
        PH_IDLE  = 2'd0,  // waiting for a trigger
        PH_ARMED = 2'd1,  // trigger taken, waiting for a word boundary
        PH_FILL  = 2'd2,  // writing words into the channel buffers
        PH_DUMP  = 2'd3   // buffers being streamed out of the UART
    } cap_phase_t;

    // UART payload width
    localparam int BYTE_BITS = 8;

    // bytes sent per captured word, high byte first
    localparam int WORD_BYTES = 2;

endpackage

//--- dump/dump_sequencer.sv
`timescale 1ns/10ps

module dump_sequencer import dump_pkg::*; #(
    parameter int NUM_CH        = 4,
    parameter int WORD_BITS     = 16,
    parameter int CAPTURE_WORDS = 8,
    parameter int ADDR_BITS     = 3
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 dump_start,
    buf_rd_if.host               rd [NUM_CH],
    input  logic                 tx_busy,
    output logic [BYTE_BITS-1:0] tx_data,
    output logic                 tx_start,
    output logic                 dump_done
);

    localparam int CH_BITS   = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;
    localparam int BIDX_BITS = (WORD_BYTES > 1) ? $clog2(WORD_BYTES) : 1;
    localparam logic [CH_BITS-1:0]   LAST_CH   = CH_BITS'(NUM_CH - 1);
    localparam logic [ADDR_BITS-1:0] LAST_ADDR = ADDR_BITS'(CAPTURE_WORDS - 1);
    localparam logic [BIDX_BITS-1:0] LAST_BYTE = BIDX_BITS'(WORD_BYTES - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_READ,  // read request to the selected buffer
        S_WAIT,  // wait for rd_valid
        S_SEND,  // hand the next byte to the UART
        S_BUSY   // wait for the UART frame to end
    } seq_state_t;

    seq_state_t           state;
    logic [CH_BITS-1:0]   ch_idx;
    logic [ADDR_BITS-1:0] addr;
    logic [BIDX_BITS-1:0] byte_idx;
    logic [WORD_BITS-1:0] word_q;
    logic                 rd_en;
    int                   byte_sel;

    logic [WORD_BITS-1:0] rd_data_arr [NUM_CH];
    logic [NUM_CH-1:0]    rd_valid_vec;

    assign rd_en    = (state == S_READ);
    assign byte_sel = WORD_BYTES - 1 - int'(byte_idx); // high byte first

    // interface arrays only take constant indices, so fan out here
    for (genvar g = 0; g < NUM_CH; g++) begin : g_rd
        assign rd[g].rd_en     = rd_en && (ch_idx == CH_BITS'(g));
        assign rd[g].rd_addr   = addr;
        assign rd_data_arr[g]  = rd[g].rd_data;
        assign rd_valid_vec[g] = rd[g].rd_valid;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= S_IDLE;
            ch_idx    <= '0;
            addr      <= '0;
            byte_idx  <= '0;
            tx_start  <= 1'b0;
            dump_done <= 1'b0;
        end else begin
            tx_start  <= 1'b0;
            dump_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (dump_start) begin
                        ch_idx <= '0;
                        addr   <= '0;
                        state  <= S_READ;
                    end
                end
                S_READ: state <= S_WAIT;
                S_WAIT: begin
                    if (rd_valid_vec[ch_idx]) begin
                        byte_idx <= '0;
                        state    <= S_SEND;
                    end
                end
                S_SEND: begin
                    if (!tx_busy) begin
                        tx_start <= 1'b1;
                        state    <= S_BUSY;
                    end
                end
                S_BUSY: begin
                    // tx_busy rises a cycle after tx_start
                    if (!tx_busy && !tx_start) begin
                        if (byte_idx != LAST_BYTE) begin
                            byte_idx <= byte_idx + 1'b1;
                            state    <= S_SEND;
                        end else if (addr != LAST_ADDR) begin
                            addr  <= addr + 1'b1;
                            state <= S_READ;
                        end else if (ch_idx != LAST_CH) begin
                            ch_idx <= ch_idx + 1'b1;
                            addr   <= '0;
                            state  <= S_READ;
                        end else begin
                            dump_done <= 1'b1; // last stop bit is out
                            state     <= S_IDLE;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_WAIT && rd_valid_vec[ch_idx]) begin
            word_q <= rd_data_arr[ch_idx];
        end
        if (state == S_SEND && !tx_busy) begin
            tx_data <= word_q[byte_sel*BYTE_BITS +: BYTE_BITS];
        end
    end

    a_no_start_while_busy: assert property (@(posedge clk) disable iff (!rst)
        tx_start |-> !tx_busy)
        else $error("tx_start issued while the UART is busy");

endmodule

//--- dump/uart_tx.sv
`timescale 1ns/10ps

module uart_tx import dump_pkg::*; #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [BYTE_BITS-1:0] tx_data,
    input  logic                 tx_start,
    output logic                 tx_serial,
    output logic                 tx_busy
);

    localparam int FRAME_BITS = BYTE_BITS + 2; // start, data, stop
    localparam int CNT_BITS   = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam int IDX_BITS   = $clog2(FRAME_BITS);

    logic [CNT_BITS-1:0]  clk_cnt;  // cycles within the current bit
    logic [IDX_BITS-1:0]  bit_idx;  // 0 is the start bit
    logic [BYTE_BITS:0]   shifter;  // data bits then the stop bit
    logic                 bit_end;

    assign bit_end = (clk_cnt == CNT_BITS'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (!rst) begin
            tx_busy   <= 1'b0;
            tx_serial <= 1'b1; // line idles high
            clk_cnt   <= '0;
            bit_idx   <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                tx_busy   <= 1'b1;
                tx_serial <= 1'b0; // start bit
                clk_cnt   <= '0;
                bit_idx   <= '0;
            end
        end else if (bit_end) begin
            clk_cnt <= '0;
            if (bit_idx == IDX_BITS'(FRAME_BITS - 1)) begin
                tx_busy   <= 1'b0; // stop bit done
                tx_serial <= 1'b1;
            end else begin
                bit_idx   <= bit_idx + 1'b1;
                tx_serial <= shifter[0];
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // LSB first, ones fill in from the top
    always_ff @(posedge clk) begin
        if (!tx_busy && tx_start) begin
            shifter <= {1'b1, tx_data};
        end else if (tx_busy && bit_end) begin
            shifter <= {1'b1, shifter[BYTE_BITS:1]};
        end
    end

endmodule

//--- hw/capture_control.sv
`timescale 1ns/10ps

module capture_control import dump_pkg::*; #(
    parameter int WORD_BITS     = 16,
    parameter int CAPTURE_WORDS = 8,
    parameter int ADDR_BITS     = 3
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 trig,
    input  logic                 dump_done,
    output logic                 word_strobe,
    output logic                 wr_en,
    output logic [ADDR_BITS-1:0] wr_addr,
    output logic                 dump_start,
    output cap_phase_t           phase
);

    localparam int CNT_BITS = $clog2(WORD_BITS);
    localparam logic [ADDR_BITS-1:0] LAST_ADDR = ADDR_BITS'(CAPTURE_WORDS - 1);

    logic [CNT_BITS-1:0] bit_cnt;

    assign word_strobe = (bit_cnt == CNT_BITS'(WORD_BITS - 1)); // last bit of a word
    assign wr_en       = word_strobe && (phase == PH_FILL);

    // free running word timer
    always_ff @(posedge clk) begin
        if (!rst) begin
            bit_cnt <= '0;
        end else if (word_strobe) begin
            bit_cnt <= '0;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            phase      <= PH_IDLE;
            wr_addr    <= '0;
            dump_start <= 1'b0;
        end else begin
            dump_start <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    if (trig) begin
                        phase <= PH_ARMED; // later triggers are ignored
                    end
                end
                PH_ARMED: begin
                    if (word_strobe) begin
                        phase   <= PH_FILL; // align to boundary, no write yet
                        wr_addr <= '0;
                    end
                end
                PH_FILL: begin
                    if (wr_en) begin
                        wr_addr <= wr_addr + 1'b1;
                        if (wr_addr == LAST_ADDR) begin
                            phase      <= PH_DUMP;
                            dump_start <= 1'b1;
                        end
                    end
                end
                PH_DUMP: begin
                    if (dump_done) begin
                        phase <= PH_IDLE;
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    a_dump_start_on_fill_end: assert property (@(posedge clk) disable iff (!rst)
        dump_start |-> (phase == PH_DUMP) && ($past(phase) == PH_FILL))
        else $error("dump_start outside the fill to dump transition");

endmodule

//--- hw/hex_dump_top.sv
`timescale 1ns/10ps

module hex_dump_top import dump_pkg::*; #(
    parameter int NUM_CH        = 4,
    parameter int WORD_BITS     = 16,
    parameter int CAPTURE_WORDS = 8,
    parameter int CLKS_PER_BIT  = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [NUM_CH-1:0] sig,
    input  logic              trig,
    output logic              tx_serial,
    output logic              busy
);

    localparam int ADDR_BITS = (CAPTURE_WORDS > 1) ? $clog2(CAPTURE_WORDS) : 1;

    logic                 word_strobe;
    logic                 wr_en;
    logic [ADDR_BITS-1:0] wr_addr;
    logic                 dump_start;
    logic                 dump_done;
    cap_phase_t           phase;
    logic [BYTE_BITS-1:0] tx_data;
    logic                 tx_start;
    logic                 tx_busy;

    buf_rd_if #(.WORD_BITS(WORD_BITS), .ADDR_BITS(ADDR_BITS)) rd_bus [NUM_CH] ();

    assign busy = (phase != PH_IDLE);

    capture_control #(
        .WORD_BITS     (WORD_BITS),
        .CAPTURE_WORDS (CAPTURE_WORDS),
        .ADDR_BITS     (ADDR_BITS)
    ) u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .trig        (trig),
        .dump_done   (dump_done),
        .word_strobe (word_strobe),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .dump_start  (dump_start),
        .phase       (phase)
    );

    for (genvar g = 0; g < NUM_CH; g++) begin : g_ch
        capture_channel #(
            .WORD_BITS     (WORD_BITS),
            .CAPTURE_WORDS (CAPTURE_WORDS),
            .ADDR_BITS     (ADDR_BITS)
        ) u_chan (
            .clk         (clk),
            .rst         (rst),
            .sig         (sig[g]),
            .word_strobe (word_strobe),
            .wr_en       (wr_en),
            .wr_addr     (wr_addr),
            .rd          (rd_bus[g])
        );
    end

    dump_sequencer #(
        .NUM_CH        (NUM_CH),
        .WORD_BITS     (WORD_BITS),
        .CAPTURE_WORDS (CAPTURE_WORDS),
        .ADDR_BITS     (ADDR_BITS)
    ) u_seq (
        .clk        (clk),
        .rst        (rst),
        .dump_start (dump_start),
        .rd         (rd_bus),
        .tx_busy    (tx_busy),
        .tx_data    (tx_data),
        .tx_start   (tx_start),
        .dump_done  (dump_done)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_tx (
        .clk       (clk),
        .rst       (rst),
        .tx_data   (tx_data),
        .tx_start  (tx_start),
        .tx_serial (tx_serial),
        .tx_busy   (tx_busy)
    );

    // the dump splits each word into exactly WORD_BYTES bytes
    a_word_fits_bytes: assert property (@(posedge clk)
        WORD_BITS == BYTE_BITS * WORD_BYTES)
        else $error("WORD_BITS does not match the byte dump");

    // no frame may be on the line outside a capture or dump
    a_line_idle_when_free: assert property (@(posedge clk) disable iff (!rst)
        !busy |-> tx_serial && !tx_busy)
        else $error("UART active while the unit is idle");

endmodule

//--- run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

TOP=tb_hex_dump
OBJ_DIR=obj_dir

if ! verilator --binary --timing --assert -sv -j 0 \
        --top-module "$TOP" -Mdir "$OBJ_DIR" -f all.f; then
    echo "verilator build failed"
    exit 1
fi

if [ ! -x "./$OBJ_DIR/V$TOP" ]; then
    echo "simulation binary not found"
    exit 1
fi

"./$OBJ_DIR/V$TOP"
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

echo "simulation completed"
exit 0

//--- tb/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD     = 20, // ns
    parameter int RST_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // active low, released on a rising edge
    initial begin
        rst <= 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b1;
    end

endmodule

//--- tb/tb_hex_dump.sv
`timescale 1ns/10ps

module tb_hex_dump import dump_pkg::*; ();

    localparam int NUM_CH        = 4;
    localparam int WORD_BITS     = 16;
    localparam int CAPTURE_WORDS = 8;
    localparam int CLKS_PER_BIT  = 8;
    localparam int CLK_PERIOD    = 20; // ns
    localparam int DUMP_BYTES    = NUM_CH * CAPTURE_WORDS * WORD_BYTES;
    localparam int NUM_ROWS      = 6;
    localparam longint WATCHDOG_NS = longint'(NUM_ROWS)
        * (CAPTURE_WORDS * 16 + 80 * 10 * CLKS_PER_BIT + 200) * CLK_PERIOD * 2;

    // one trigger per row with its gap after the previous dump
    typedef struct packed {
        logic [15:0] gap;      // cycles before the trigger
        logic        extra;    // second trigger while busy
        logic [15:0] extra_at; // cycles after the first trigger
    } stim_row_t;

    stim_row_t rows [NUM_ROWS] = '{
        '{16'd5,  1'b0, 16'd0},
        '{16'd0,  1'b1, 16'd1},    // right after acceptance
        '{16'd9,  1'b0, 16'd0},
        '{16'd14, 1'b1, 16'd60},   // during the fill
        '{16'd23, 1'b1, 16'd2000}, // in the middle of the dump
        '{16'd31, 1'b0, 16'd0}
    };

    logic              clk;
    logic              rst;
    logic [NUM_CH-1:0] sig  = '0;
    logic              trig = 1'b0;
    logic              tx_serial;
    logic              busy;

    logic [31:0]          lcg_state = 32'h899f44b4;
    int                   cyc = 0;    // cycles since reset release
    logic [WORD_BITS-1:0] shift_m [NUM_CH];
    logic [WORD_BITS-1:0] exp_mem [NUM_CH][CAPTURE_WORDS];
    cap_phase_t           m_phase = PH_IDLE;
    int                   m_addr = 0;
    int                   dumps_done = 0; // bumped by the stimulus
    int                   dumps_seen = 0; // followed by the model
    logic [BYTE_BITS-1:0] rx_q [$];

    tb_clock #(
        .PERIOD     (CLK_PERIOD),
        .RST_CYCLES (3)
    ) u_clock (
        .clk (clk),
        .rst (rst)
    );

    hex_dump_top #(
        .NUM_CH        (NUM_CH),
        .WORD_BITS     (WORD_BITS),
        .CAPTURE_WORDS (CAPTURE_WORDS),
        .CLKS_PER_BIT  (CLKS_PER_BIT)
    ) u_dut (
        .clk       (clk),
        .rst       (rst),
        .sig       (sig),
        .trig      (trig),
        .tx_serial (tx_serial),
        .busy      (busy)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "run stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    // inputs read here are the values the DUT samples on this edge
    always @(posedge clk) begin
        logic strobe;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            shift_m[ch] = {shift_m[ch][WORD_BITS-2:0], sig[ch]}; // oldest sample at the MSB
        end
        if (rst) begin
            strobe = (cyc % WORD_BITS) == WORD_BITS - 1; // word boundary
            cyc = cyc + 1;
            case (m_phase)
                PH_IDLE: if (trig) m_phase = PH_ARMED;
                PH_ARMED: begin
                    if (strobe) begin
                        m_phase = PH_FILL;
                        m_addr  = 0;
                    end
                end
                PH_FILL: begin
                    if (strobe) begin
                        for (int ch = 0; ch < NUM_CH; ch++) begin
                            exp_mem[ch][m_addr] = shift_m[ch];
                        end
                        if (m_addr == CAPTURE_WORDS - 1) begin
                            m_phase = PH_DUMP;
                        end else begin
                            m_addr = m_addr + 1;
                        end
                    end
                end
                PH_DUMP: begin
                    if (dumps_done != dumps_seen) begin
                        dumps_seen = dumps_seen + 1;
                        m_phase    = PH_IDLE;
                    end
                end
            endcase
        end
        lcg_state = lcg_next(lcg_state);
        sig <= lcg_state[31 -: NUM_CH];
    end

    // 8N1 receiver sampling each bit near its middle
    initial begin : uart_decode
        logic [BYTE_BITS-1:0] data;
        forever begin
            @(negedge clk);
            if (rst && tx_serial == 1'b0) begin
                repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);
                if (tx_serial !== 1'b0) begin
                    abort_run("start bit on tx_serial is shorter than half a bit");
                end
                for (int i = 0; i < BYTE_BITS; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    data[i] = tx_serial; // LSB first
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                if (tx_serial !== 1'b1) begin
                    abort_run($sformatf("framing error, stop bit of byte %0d is low",
                                        rx_q.size()));
                end
                check_value("busy", 32'(busy), 32'd1);
                rx_q.push_back(data);
            end
        end
    end

    task automatic pulse_trig();
        @(posedge clk);
        trig <= 1'b1;
        @(posedge clk);
        trig <= 1'b0; // sampled on this edge
    endtask

    task automatic finish_dump(input int base);
        int n;
        while (rx_q.size() < base + DUMP_BYTES) @(posedge clk);
        @(negedge clk);
        n = 0;
        while (busy) begin
            if (n > 2 * CLKS_PER_BIT) begin
                abort_run("busy stayed high after the last stop bit");
            end
            n++;
            @(negedge clk);
        end
        if (n < CLKS_PER_BIT / 2) begin
            abort_run("busy fell before the last stop bit ended");
        end
        check_value("tx_serial", 32'(tx_serial), 32'd1);
        dumps_done++; // model goes back to idle
    endtask

    task automatic compare_dump(input int base);
        int                   k;
        logic [WORD_BITS-1:0] w;
        k = base;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            for (int a = 0; a < CAPTURE_WORDS; a++) begin
                w = exp_mem[ch][a];
                check_value($sformatf("byte ch%0d addr%0d high", ch, a),
                            32'(rx_q[k]), 32'(w[WORD_BITS-1 -: BYTE_BITS]));
                check_value($sformatf("byte ch%0d addr%0d low", ch, a),
                            32'(rx_q[k+1]), 32'(w[BYTE_BITS-1:0]));
                k += WORD_BYTES;
            end
        end
    endtask

    initial begin : stimulus
        int base;
        base = 0;
        wait (rst == 1'b1);
        repeat (40) begin
            @(negedge clk);
            check_value("busy", 32'(busy), 32'd0);
            check_value("tx_serial", 32'(tx_serial), 32'd1);
        end
        check_value("byte count", 32'(rx_q.size()), 32'd0); // nothing without a trigger
        for (int r = 0; r < NUM_ROWS; r++) begin
            repeat (int'(rows[r].gap)) @(posedge clk);
            @(negedge clk);
            check_value("busy", 32'(busy), 32'd0);
            check_value("byte count", 32'(rx_q.size()), 32'(base));
            pulse_trig();
            @(negedge clk);
            check_value("busy", 32'(busy), 32'd1);
            if (rows[r].extra) begin
                repeat (int'(rows[r].extra_at)) @(posedge clk);
                @(negedge clk);
                check_value("busy", 32'(busy), 32'd1);
                pulse_trig(); // must be ignored
            end
            finish_dump(base);
            compare_dump(base);
            base += DUMP_BYTES;
        end
        repeat (30 * CLKS_PER_BIT) @(negedge clk);
        check_value("byte count", 32'(rx_q.size()), 32'(base));
        $display("=== PASS ===");
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout, the dumps did not complete within %0d ns", WATCHDOG_NS);
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

endmodule
